// ==== Makefile ====
# Verilator build and run of the fetch testbench

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the fetch testbench"
	@echo "  clean  remove the build directory"

test:
	verilator --binary --timing --assert -f filelist.f --top-module fetch_tb -Mdir obj_dir
	@out=$$(./obj_dir/Vfetch_tb +verilator+error+limit+100); \
	echo "$$out"; \
	echo "$$out" | grep -q "TEST RESULT: PASS"

clean:
	rm -rf obj_dir

// ==== filelist.f ====
+incdir+src
src/fetch_pkg.sv
src/fetch_stream_if.sv
src/prefetch_buffer.sv
src/compressed_decoder.sv
src/if_stage.sv
src/fetch_top.sv
testbench/fetch_assertions.sv
testbench/fetch_tb.sv

// ==== src/compressed_decoder.sv ====
////////////////////////////////////////////////////////////////////////////
// compressed decoder
// expands c.addi, c.li, c.lw, c.sw, c.j, c.mv and c.add to RV32I words
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module compressed_decoder (
  input  fetch_pkg::instr_t instr_i,
  output fetch_pkg::instr_t instr_o,
  output logic              is_compressed_o,
  output logic              illegal_instr_o
);

  // quadrants 0..2 are 16 bit, quadrant 3 is a full word
  assign is_compressed_o = (instr_i[1:0] != 2'b11);

  always_comb begin
    illegal_instr_o = 1'b0;
    instr_o         = instr_i;  // raw word unless expanded below

    unique case (instr_i[1:0])
      // quadrant 0, loads and stores on x8..x15
      2'b00: begin
        case (instr_i[15:13])
          3'b010: begin  // c.lw -> lw rd', uimm(rs1')
            instr_o = {5'b0, instr_i[5], instr_i[12:10], instr_i[6], 2'b00,
                       2'b01, instr_i[9:7], 3'b010, 2'b01, instr_i[4:2], 7'b0000011};
          end
          3'b110: begin  // c.sw -> sw rs2', uimm(rs1')
            instr_o = {5'b0, instr_i[5], instr_i[12], 2'b01, instr_i[4:2],
                       2'b01, instr_i[9:7], 3'b010, instr_i[11:10], instr_i[6],
                       2'b00, 7'b0100011};
          end
          default: illegal_instr_o = 1'b1;
        endcase
      end

      // quadrant 1, immediates and jumps
      2'b01: begin
        case (instr_i[15:13])
          3'b000: begin  // c.addi, c.nop when rd is x0
            instr_o = {{6{instr_i[12]}}, instr_i[12], instr_i[6:2], instr_i[11:7],
                       3'b000, instr_i[11:7], 7'b0010011};
          end
          3'b010: begin  // c.li -> addi rd, x0, imm
            instr_o = {{6{instr_i[12]}}, instr_i[12], instr_i[6:2], 5'b0,
                       3'b000, instr_i[11:7], 7'b0010011};
          end
          3'b101: begin
            // c.j -> jal x0, offset; bits land in jal order 20, 10:1, 11, 19:12
            instr_o = {instr_i[12], instr_i[8], instr_i[10:9], instr_i[6], instr_i[7],
                       instr_i[2], instr_i[11], instr_i[5:3], {9{instr_i[12]}},
                       5'b0, 7'b1101111};
          end
          default: illegal_instr_o = 1'b1;
        endcase
      end

      // quadrant 2, register moves; rs2 of x0 would be c.jr or c.jalr
      2'b10: begin
        if (instr_i[15:13] == 3'b100 && instr_i[6:2] != 5'b0) begin
          if (instr_i[12]) begin  // c.add -> add rd, rd, rs2
            instr_o = {7'b0, instr_i[6:2], instr_i[11:7], 3'b000,
                       instr_i[11:7], 7'b0110011};
          end else begin          // c.mv -> add rd, x0, rs2
            instr_o = {7'b0, instr_i[6:2], 5'b0, 3'b000,
                       instr_i[11:7], 7'b0110011};
          end
        end else begin
          illegal_instr_o = 1'b1;
        end
      end

      default: ;  // 32 bit word passes through
    endcase
  end

endmodule

// ==== src/fetch_defines.svh ====
////////////////////////////////////////////////////////////////////////////
// fetch defines
// sizing of the prefetch FIFO, the bus request limit and boot alignment
////////////////////////////////////////////////////////////////////////////

`ifndef FETCH_DEFINES_SVH
`define FETCH_DEFINES_SVH

// entries in the prefetch FIFO, power of two
`define FETCH_FIFO_DEPTH 4

// bus requests allowed in flight at once
`define FETCH_MAX_OUTSTANDING 2

// low boot address bits forced to zero
`define FETCH_BOOT_ALIGN 2

`endif

// ==== src/fetch_pkg.sv ====
////////////////////////////////////////////////////////////////////////////
// fetch package
// address, instruction and selector types of the fetch subsystem
////////////////////////////////////////////////////////////////////////////

package fetch_pkg;

  typedef logic [31:0] addr_t;       // byte address
  typedef logic [31:0] instr_t;      // raw or expanded instruction word
  typedef logic [23:0] trap_base_t;  // mtvec bits 31:8
  typedef logic [4:0]  cause_t;      // irq cause, selects vector slot

  // next pc source
  typedef enum logic [2:0] {
    PC_BOOT      = 3'b000,
    PC_FENCEI    = 3'b001,
    PC_JUMP      = 3'b010,  // target from ID
    PC_BRANCH    = 3'b011,  // target from EX
    PC_EXCEPTION = 3'b100,
    PC_MRET      = 3'b101
  } pc_mux_e;

  // trap vector flavour
  typedef enum logic {
    EXC_PC_EXCEPTION = 1'b0,  // all exceptions at the base
    EXC_PC_IRQ       = 1'b1   // interrupts vectored by cause
  } exc_pc_mux_e;

  // IF stage FSM
  typedef enum logic {
    IF_IDLE = 1'b0,
    IF_WAIT = 1'b1
  } if_fsm_e;

endpackage

// ==== src/fetch_stream_if.sv ====
////////////////////////////////////////////////////////////////////////////
// fetch stream
// fetched words from the prefetch buffer to the IF stage, branch back
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

interface fetch_stream_if;

  logic             branch;       // one cycle flush and restart
  fetch_pkg::addr_t branch_addr;  // restart address
  logic             valid;        // head word present
  logic             ready;        // stage takes the head word
  fetch_pkg::instr_t rdata;       // head word
  fetch_pkg::addr_t addr;         // address of head word

  modport stage (
    output branch, branch_addr, ready,
    input  valid, rdata, addr
  );

  modport buffer (
    input  branch, branch_addr, ready,
    output valid, rdata, addr
  );

endinterface

// ==== src/fetch_top.sv ====
////////////////////////////////////////////////////////////////////////////
// fetch top
// prefetch buffer and IF stage joined by the fetch stream
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module fetch_top (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   req_i,
  // instruction bus
  output logic                   instr_req_o,
  output fetch_pkg::addr_t       instr_addr_o,
  input  logic                   instr_gnt_i,
  input  logic                   instr_rvalid_i,
  input  fetch_pkg::instr_t      instr_rdata_i,
  // pc control from ID, EX and the CSR file
  input  logic                   pc_set_i,
  input  fetch_pkg::pc_mux_e     pc_mux_i,
  input  fetch_pkg::exc_pc_mux_e exc_pc_mux_i,
  input  fetch_pkg::trap_base_t  trap_base_i,
  input  fetch_pkg::cause_t      exc_cause_i,
  input  fetch_pkg::addr_t       boot_addr_i,
  input  fetch_pkg::addr_t       jump_target_id_i,
  input  fetch_pkg::addr_t       jump_target_ex_i,
  input  fetch_pkg::addr_t       mepc_i,
  // pipeline control
  input  logic                   halt_if_i,
  input  logic                   id_ready_i,
  input  logic                   clear_instr_valid_i,
  // to ID
  output logic                   instr_valid_id_o,
  output fetch_pkg::instr_t      instr_rdata_id_o,
  output logic                   is_compressed_id_o,
  output logic                   illegal_c_insn_id_o,
  output fetch_pkg::addr_t       pc_if_o,
  output fetch_pkg::addr_t       pc_id_o,
  output logic                   csr_mtvec_init_o,
  output logic                   perf_imiss_o,
  output logic                   if_busy_o
);

  fetch_stream_if stream_if ();

  prefetch_buffer prefetch_buffer_inst (
    .clk            (clk),
    .rst_n          (rst_n),
    .req_i          (req_i),
    .busy_o         (if_busy_o),
    .instr_req_o    (instr_req_o),
    .instr_addr_o   (instr_addr_o),
    .instr_gnt_i    (instr_gnt_i),
    .instr_rvalid_i (instr_rvalid_i),
    .instr_rdata_i  (instr_rdata_i),
    .stream         (stream_if.buffer)
  );

  if_stage if_stage_inst (
    .clk                 (clk),
    .rst_n               (rst_n),
    .req_i               (req_i),
    .pc_set_i            (pc_set_i),
    .pc_mux_i            (pc_mux_i),
    .exc_pc_mux_i        (exc_pc_mux_i),
    .trap_base_i         (trap_base_i),
    .exc_cause_i         (exc_cause_i),
    .boot_addr_i         (boot_addr_i),
    .jump_target_id_i    (jump_target_id_i),
    .jump_target_ex_i    (jump_target_ex_i),
    .mepc_i              (mepc_i),
    .halt_if_i           (halt_if_i),
    .id_ready_i          (id_ready_i),
    .clear_instr_valid_i (clear_instr_valid_i),
    .stream              (stream_if.stage),
    .instr_valid_id_o    (instr_valid_id_o),
    .instr_rdata_id_o    (instr_rdata_id_o),
    .is_compressed_id_o  (is_compressed_id_o),
    .illegal_c_insn_id_o (illegal_c_insn_id_o),
    .pc_if_o             (pc_if_o),
    .pc_id_o             (pc_id_o),
    .csr_mtvec_init_o    (csr_mtvec_init_o),
    .perf_imiss_o        (perf_imiss_o)
  );

endmodule

// ==== src/if_stage.sv ====
////////////////////////////////////////////////////////////////////////////
// IF stage
// next pc selection, fetch FSM, compressed expansion and the IF/ID register
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`include "fetch_defines.svh"

module if_stage (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   req_i,
  input  logic                   pc_set_i,
  input  fetch_pkg::pc_mux_e     pc_mux_i,
  input  fetch_pkg::exc_pc_mux_e exc_pc_mux_i,
  input  fetch_pkg::trap_base_t  trap_base_i,
  input  fetch_pkg::cause_t      exc_cause_i,
  input  fetch_pkg::addr_t       boot_addr_i,
  input  fetch_pkg::addr_t       jump_target_id_i,
  input  fetch_pkg::addr_t       jump_target_ex_i,
  input  fetch_pkg::addr_t       mepc_i,
  input  logic                   halt_if_i,
  input  logic                   id_ready_i,
  input  logic                   clear_instr_valid_i,
  fetch_stream_if.stage          stream,
  output logic                   instr_valid_id_o,
  output fetch_pkg::instr_t      instr_rdata_id_o,
  output logic                   is_compressed_id_o,
  output logic                   illegal_c_insn_id_o,
  output fetch_pkg::addr_t       pc_if_o,
  output fetch_pkg::addr_t       pc_id_o,
  output logic                   csr_mtvec_init_o,
  output logic                   perf_imiss_o
);

  fetch_pkg::if_fsm_e state_q, state_n;
  fetch_pkg::addr_t   exc_pc, fetch_addr_n;
  fetch_pkg::instr_t  instr_exp;
  logic               branch_req, valid, if_valid;
  logic               is_comp, illegal_c;

  ////////////////////////////////////////////////////////////////////////////
  // next pc
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    unique case (exc_pc_mux_i)
      fetch_pkg::EXC_PC_IRQ: exc_pc = {trap_base_i, 1'b0, exc_cause_i, 2'b00};  // vectored
      default:               exc_pc = {trap_base_i, 8'h00};
    endcase
  end

  always_comb begin
    unique case (pc_mux_i)
      fetch_pkg::PC_JUMP:      fetch_addr_n = jump_target_id_i;
      fetch_pkg::PC_BRANCH:    fetch_addr_n = jump_target_ex_i;
      fetch_pkg::PC_EXCEPTION: fetch_addr_n = exc_pc;
      fetch_pkg::PC_MRET:      fetch_addr_n = mepc_i;
      fetch_pkg::PC_FENCEI:    fetch_addr_n = pc_id_o + 32'd4;  // refetch after ID instr
      default: begin  // boot, and unused encodings
        fetch_addr_n = {boot_addr_i[31:`FETCH_BOOT_ALIGN], {`FETCH_BOOT_ALIGN{1'b0}}};
      end
    endcase
  end

  // CSR file loads mtvec on boot
  assign csr_mtvec_init_o = pc_set_i & (pc_mux_i == fetch_pkg::PC_BOOT);

  ////////////////////////////////////////////////////////////////////////////
  // fetch FSM
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    state_n    = state_q;
    branch_req = 1'b0;
    valid      = 1'b0;
    unique case (state_q)
      fetch_pkg::IF_IDLE: begin
        if (req_i) begin  // first fetch after enable
          branch_req = 1'b1;
          state_n    = fetch_pkg::IF_WAIT;
        end
      end
      fetch_pkg::IF_WAIT: valid = stream.valid;
    endcase
    // a new pc kills the head word and restarts the buffer
    if (pc_set_i) begin
      valid      = 1'b0;
      branch_req = 1'b1;
      state_n    = fetch_pkg::IF_WAIT;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= fetch_pkg::IF_IDLE;
    end else begin
      state_q <= state_n;
    end
  end

  assign if_valid = valid & id_ready_i & ~halt_if_i;  // handoff to ID

  assign stream.branch      = branch_req;
  assign stream.branch_addr = fetch_addr_n;
  assign stream.ready       = if_valid;

  assign pc_if_o      = stream.addr;
  assign perf_imiss_o = ~stream.valid | branch_req;

  compressed_decoder compressed_decoder_inst (
    .instr_i         (stream.rdata),
    .instr_o         (instr_exp),
    .is_compressed_o (is_comp),
    .illegal_instr_o (illegal_c)
  );

  ////////////////////////////////////////////////////////////////////////////
  // IF/ID register, frozen while ID stalls
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      instr_valid_id_o <= 1'b0;
    end else if (if_valid) begin
      instr_valid_id_o <= 1'b1;
    end else if (clear_instr_valid_i) begin
      instr_valid_id_o <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (if_valid) begin
      instr_rdata_id_o    <= instr_exp;
      is_compressed_id_o  <= is_comp;
      illegal_c_insn_id_o <= illegal_c;
      pc_id_o             <= pc_if_o;
    end
  end

endmodule

// ==== src/prefetch_buffer.sv ====
////////////////////////////////////////////////////////////////////////////
// prefetch buffer
// issues word requests on the instruction bus, drops the responses of a
// flushed stream and queues live words with their address in a FIFO
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`include "fetch_defines.svh"

module prefetch_buffer (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              req_i,           // fetching enabled
  output logic              busy_o,          // requests in flight
  output logic              instr_req_o,
  output fetch_pkg::addr_t  instr_addr_o,
  input  logic              instr_gnt_i,
  input  logic              instr_rvalid_i,
  input  fetch_pkg::instr_t instr_rdata_i,
  fetch_stream_if.buffer    stream
);

  localparam int OW = $clog2(`FETCH_MAX_OUTSTANDING + 1);
  localparam int PW = $clog2(`FETCH_FIFO_DEPTH);
  localparam int CW = $clog2(`FETCH_FIFO_DEPTH + 1);

  logic             req_q, req_n;
  fetch_pkg::addr_t addr_q, addr_n;    // address on the bus
  fetch_pkg::addr_t next_q, next_n;    // address of the next new request
  fetch_pkg::addr_t issue_addr;
  fetch_pkg::addr_t rsp_addr_q;        // address of the next live response
  logic             stale_q, stale_n;  // pending request predates a branch
  logic [OW-1:0]    out_q, out_n;      // accepted, awaiting rvalid
  logic [OW-1:0]    drop_q, drop_n;    // of those, owned by a flushed stream
  logic             accept, drop_rsp, push, pop, room;

  fetch_pkg::instr_t fifo_data [`FETCH_FIFO_DEPTH];
  fetch_pkg::addr_t  fifo_addr [`FETCH_FIFO_DEPTH];
  logic [PW-1:0]     wr_ptr_q, rd_ptr_q;
  logic [CW-1:0]     cnt_q, cnt_n;

  assign accept   = req_q & instr_gnt_i;
  assign drop_rsp = instr_rvalid_i & (drop_q != '0);      // oldest responses go first
  assign push     = instr_rvalid_i & ~drop_rsp & ~stream.branch;
  assign pop      = stream.valid & stream.ready & ~stream.branch;

  assign out_n = out_q + OW'(accept) - OW'(instr_rvalid_i);
  assign cnt_n = stream.branch ? '0 : cnt_q + CW'(push) - CW'(pop);

  // a branch turns everything in flight into responses to drop
  assign drop_n = stream.branch ? out_n
                                : drop_q - OW'(drop_rsp) + OW'(accept & stale_q);
  assign stale_n = (stale_q | stream.branch) & req_q & ~instr_gnt_i;

  // bus limit, and every live word must find a free FIFO entry
  assign room = (int'(out_n) < `FETCH_MAX_OUTSTANDING) &&
                (int'(cnt_n) + int'(out_n - drop_n) < `FETCH_FIFO_DEPTH);

  assign issue_addr = stream.branch ? stream.branch_addr : next_q;

  ////////////////////////////////////////////////////////////////////////////
  // request issue
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    req_n  = req_q;
    addr_n = addr_q;
    next_n = issue_addr;
    if (!(req_q && !instr_gnt_i)) begin  // address must hold until granted
      req_n  = req_i & room;
      addr_n = issue_addr;
      if (req_n) begin
        next_n = issue_addr + 32'd4;
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      req_q      <= 1'b0;
      addr_q     <= '0;
      next_q     <= '0;
      rsp_addr_q <= '0;
      stale_q    <= 1'b0;
      out_q      <= '0;
      drop_q     <= '0;
      wr_ptr_q   <= '0;
      rd_ptr_q   <= '0;
      cnt_q      <= '0;
    end else begin
      req_q   <= req_n;
      addr_q  <= addr_n;
      next_q  <= next_n;
      stale_q <= stale_n;
      out_q   <= out_n;
      drop_q  <= drop_n;
      cnt_q   <= cnt_n;
      if (stream.branch) begin  // flush
        rsp_addr_q <= stream.branch_addr;
        wr_ptr_q   <= '0;
        rd_ptr_q   <= '0;
      end else begin
        if (push) begin
          rsp_addr_q <= rsp_addr_q + 32'd4;
          wr_ptr_q   <= wr_ptr_q + PW'(1);
        end
        if (pop) begin
          rd_ptr_q <= rd_ptr_q + PW'(1);
        end
      end
    end
  end

  // FIFO storage
  always_ff @(posedge clk) begin
    if (push) begin
      fifo_data[wr_ptr_q] <= instr_rdata_i;
      fifo_addr[wr_ptr_q] <= rsp_addr_q;
    end
  end

  assign stream.valid = (cnt_q != '0);
  assign stream.rdata = fifo_data[rd_ptr_q];
  assign stream.addr  = fifo_addr[rd_ptr_q];

  assign instr_req_o  = req_q;
  assign instr_addr_o = addr_q;
  assign busy_o       = (out_q != '0);

endmodule

// ==== testbench/fetch_assertions.sv ====
////////////////////////////////////////////////////////////////////////////
// fetch checker
// reference model of the fetch address stream and bound property checks
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`include "fetch_defines.svh"

module fetch_assertions (
  input logic                   clk,
  input logic                   rst_n,
  input logic                   pc_set_i,
  input fetch_pkg::pc_mux_e     pc_mux_i,
  input fetch_pkg::exc_pc_mux_e exc_pc_mux_i,
  input fetch_pkg::trap_base_t  trap_base_i,
  input fetch_pkg::cause_t      exc_cause_i,
  input fetch_pkg::addr_t       boot_addr_i,
  input fetch_pkg::addr_t       jump_target_id_i,
  input fetch_pkg::addr_t       jump_target_ex_i,
  input fetch_pkg::addr_t       mepc_i,
  input logic                   halt_if_i,
  input logic                   id_ready_i,
  input logic                   clear_instr_valid_i,
  input logic                   instr_req_o,
  input fetch_pkg::addr_t       instr_addr_o,
  input logic                   instr_gnt_i,
  input logic                   instr_rvalid_i,
  input logic                   instr_valid_id_o,
  input fetch_pkg::instr_t      instr_rdata_id_o,
  input logic                   is_compressed_id_o,
  input logic                   illegal_c_insn_id_o,
  input fetch_pkg::addr_t       pc_if_o,
  input fetch_pkg::addr_t       pc_id_o,
  input logic                   csr_mtvec_init_o,
  input logic                   perf_imiss_o,
  input logic                   if_busy_o,
  input logic                   load_i          // word handed to ID this cycle
);

  int               err_count = 0;
  fetch_pkg::addr_t exp_pc_q;   // pc of the next word ID should see
  fetch_pkg::addr_t target;
  logic [3:0]       out_q;      // bus requests awaiting rvalid
  logic             stall;

  // expected {illegal, compressed, instruction} for a loaded pc
  function automatic logic [33:0] expected_id(fetch_pkg::addr_t a);
    if (a < 32'h100) return {2'b11, 32'h0000_8002};  // c.jr form, not supported
    case (a)
      32'h400: return {2'b01, 32'h0010_8093};  // c.addi x1, 1
      32'h404: return {2'b01, 32'hfff0_0113};  // c.li x2, -1
      32'h408: return {2'b01, 32'h0044_2483};  // c.lw x9, 4(x8)
      32'h40c: return {2'b01, 32'h0094_2423};  // c.sw x9, 8(x8)
      32'h410: return {2'b01, 32'h0040_01b3};  // c.mv x3, x4
      32'h414: return {2'b01, 32'h0041_81b3};  // c.add x3, x4
      32'h418: return {2'b01, 32'h0080_006f};  // c.j 8
      32'h41c: return {2'b01, 32'h0000_0013};  // c.nop
      default: return {2'b00, a[31:2], 2'b11};
    endcase
  endfunction

  //////////////////////////////////////////////////////////////////////////
  // reference model
  //////////////////////////////////////////////////////////////////////////

  always_comb begin
    case (pc_mux_i)
      fetch_pkg::PC_JUMP:   target = jump_target_id_i;
      fetch_pkg::PC_BRANCH: target = jump_target_ex_i;
      fetch_pkg::PC_MRET:   target = mepc_i;
      fetch_pkg::PC_FENCEI: target = pc_id_o + 32'd4;
      fetch_pkg::PC_EXCEPTION: begin
        if (exc_pc_mux_i == fetch_pkg::EXC_PC_IRQ)
          target = {trap_base_i, 1'b0, exc_cause_i, 2'b00};
        else
          target = {trap_base_i, 8'h00};
      end
      default: target = {boot_addr_i[31:2], 2'b00};
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      exp_pc_q <= '0;
      out_q    <= '0;
    end else begin
      if (pc_set_i) exp_pc_q <= target;
      else if (load_i) exp_pc_q <= exp_pc_q + 32'd4;  // sequential fetch
      out_q <= out_q + 4'(instr_req_o & instr_gnt_i) - 4'(instr_rvalid_i);
    end
  end

  assign stall = !id_ready_i || halt_if_i;

  //////////////////////////////////////////////////////////////////////////
  // properties
  //////////////////////////////////////////////////////////////////////////

  reset_idle: assert property (@(posedge clk)
    !rst_n |-> !instr_req_o && !instr_valid_id_o && !csr_mtvec_init_o)
    else begin
      err_count++;
      $error("ERROR %0t: outputs active in reset", $time);
    end

  pc_order: assert property (@(posedge clk) disable iff (!rst_n)
    load_i |=> instr_valid_id_o && pc_id_o == $past(exp_pc_q))
    else begin
      err_count++;
      $error("ERROR %0t: wrong pc_id_o %h", $time, pc_id_o);
    end

  // head address is the pc that ID is about to see
  head_pc: assert property (@(posedge clk) disable iff (!rst_n)
    load_i |-> pc_if_o == exp_pc_q)
    else begin
      err_count++;
      $error("ERROR %0t: wrong pc_if_o %h", $time, pc_if_o);
    end

  word_match: assert property (@(posedge clk) disable iff (!rst_n)
    load_i |=> {illegal_c_insn_id_o, is_compressed_id_o, instr_rdata_id_o}
               == expected_id(pc_id_o))
    else begin
      err_count++;
      $error("ERROR %0t: wrong word at %h", $time, pc_id_o);
    end

  hold_on_stall: assert property (@(posedge clk) disable iff (!rst_n)
    stall && instr_valid_id_o && !clear_instr_valid_i |=>
      $stable({instr_valid_id_o, instr_rdata_id_o, is_compressed_id_o,
               illegal_c_insn_id_o, pc_id_o}))
    else begin
      err_count++;
      $error("ERROR %0t: IF/ID changed in stall", $time);
    end

  clear_drop: assert property (@(posedge clk) disable iff (!rst_n)
    clear_instr_valid_i && !load_i |=> !instr_valid_id_o)
    else begin
      err_count++;
      $error("ERROR %0t: instr_valid_id_o kept after clear", $time);
    end

  bus_limit: assert property (@(posedge clk) disable iff (!rst_n)
    int'(out_q) <= `FETCH_MAX_OUTSTANDING)
    else begin
      err_count++;
      $error("ERROR %0t: too many requests out", $time);
    end

  // busy follows the bus side count of accepted requests
  busy_match: assert property (@(posedge clk) disable iff (!rst_n)
    if_busy_o == (out_q != '0))
    else begin
      err_count++;
      $error("ERROR %0t: if_busy_o wrong", $time);
    end

  addr_hold: assert property (@(posedge clk) disable iff (!rst_n)
    instr_req_o && !instr_gnt_i |=> instr_req_o && $stable(instr_addr_o))
    else begin
      err_count++;
      $error("ERROR %0t: request dropped before grant", $time);
    end

  // a new pc is a miss, a handed over word is not
  imiss_flag: assert property (@(posedge clk) disable iff (!rst_n)
    (pc_set_i || load_i) |-> perf_imiss_o == pc_set_i)
    else begin
      err_count++;
      $error("ERROR %0t: perf_imiss_o wrong", $time);
    end

  mtvec_pulse: assert property (@(posedge clk) disable iff (!rst_n)
    csr_mtvec_init_o == (pc_set_i && pc_mux_i == fetch_pkg::PC_BOOT))
    else begin
      err_count++;
      $error("ERROR %0t: csr_mtvec_init_o wrong", $time);
    end

endmodule

bind fetch_top fetch_assertions fetch_assertions_inst (
  .clk                 (clk),
  .rst_n               (rst_n),
  .pc_set_i            (pc_set_i),
  .pc_mux_i            (pc_mux_i),
  .exc_pc_mux_i        (exc_pc_mux_i),
  .trap_base_i         (trap_base_i),
  .exc_cause_i         (exc_cause_i),
  .boot_addr_i         (boot_addr_i),
  .jump_target_id_i    (jump_target_id_i),
  .jump_target_ex_i    (jump_target_ex_i),
  .mepc_i              (mepc_i),
  .halt_if_i           (halt_if_i),
  .id_ready_i          (id_ready_i),
  .clear_instr_valid_i (clear_instr_valid_i),
  .instr_req_o         (instr_req_o),
  .instr_addr_o        (instr_addr_o),
  .instr_gnt_i         (instr_gnt_i),
  .instr_rvalid_i      (instr_rvalid_i),
  .instr_valid_id_o    (instr_valid_id_o),
  .instr_rdata_id_o    (instr_rdata_id_o),
  .is_compressed_id_o  (is_compressed_id_o),
  .illegal_c_insn_id_o (illegal_c_insn_id_o),
  .pc_if_o             (pc_if_o),
  .pc_id_o             (pc_id_o),
  .csr_mtvec_init_o    (csr_mtvec_init_o),
  .perf_imiss_o        (perf_imiss_o),
  .if_busy_o           (if_busy_o),
  .load_i              (stream_if.ready)
);

// ==== testbench/fetch_tb.sv ====
////////////////////////////////////////////////////////////////////////////
// fetch testbench
// memory model with random grant and latency, pc control sequence
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module fetch_tb;

  localparam int TIMEOUT_CYCLES = 4000;

  logic clk, rst_n, req, pc_set, halt, id_ready, clr_valid;
  logic gnt, rvalid;
  fetch_pkg::instr_t      rdata;
  fetch_pkg::pc_mux_e     pc_mux;
  fetch_pkg::exc_pc_mux_e exc_mux;
  fetch_pkg::trap_base_t  trap_base;
  fetch_pkg::cause_t      cause;
  fetch_pkg::addr_t       boot_addr, jump_id, jump_ex, mepc;
  logic bus_req, valid_id, comp_id, ill_id, mtvec_init, imiss, busy;
  fetch_pkg::addr_t bus_addr, pc_if, pc_id;
  fetch_pkg::instr_t rdata_id;

  logic [31:0]      lfsr_q = 32'h8d81c739;
  fetch_pkg::addr_t pending [$];  // accepted addresses, oldest first
  int               cycles = 0;

  fetch_top fetch_top_inst (
    .clk(clk), .rst_n(rst_n), .req_i(req),
    .instr_req_o(bus_req), .instr_addr_o(bus_addr), .instr_gnt_i(gnt),
    .instr_rvalid_i(rvalid), .instr_rdata_i(rdata),
    .pc_set_i(pc_set), .pc_mux_i(pc_mux), .exc_pc_mux_i(exc_mux),
    .trap_base_i(trap_base), .exc_cause_i(cause), .boot_addr_i(boot_addr),
    .jump_target_id_i(jump_id), .jump_target_ex_i(jump_ex), .mepc_i(mepc),
    .halt_if_i(halt), .id_ready_i(id_ready), .clear_instr_valid_i(clr_valid),
    .instr_valid_id_o(valid_id), .instr_rdata_id_o(rdata_id),
    .is_compressed_id_o(comp_id), .illegal_c_insn_id_o(ill_id),
    .pc_if_o(pc_if), .pc_id_o(pc_id), .csr_mtvec_init_o(mtvec_init),
    .perf_imiss_o(imiss), .if_busy_o(busy)
  );

  always #4 clk = ~clk;

  // galois LFSR, one step per bit
  function automatic logic rand_bit();
    logic b;
    b      = lfsr_q[0];
    lfsr_q = (lfsr_q >> 1) ^ (b ? 32'h8020_0003 : 32'h0);
    return b;
  endfunction

  function automatic fetch_pkg::instr_t mem_word(fetch_pkg::addr_t a);
    if (a < 32'h100) return 32'h0000_8002;  // unsupported 16 bit form
    case (a)
      32'h400: return 32'h0000_0085;
      32'h404: return 32'h0000_517d;
      32'h408: return 32'h0000_4044;
      32'h40c: return 32'h0000_c404;
      32'h410: return 32'h0000_8192;
      32'h414: return 32'h0000_9192;
      32'h418: return 32'h0000_a021;
      32'h41c: return 32'h0000_0001;
      default: return {a[31:2], 2'b11};   // plain 32 bit opcode
    endcase
  endfunction

  // bus slave; responses only for requests accepted at earlier edges
  always @(negedge clk) begin
    if (!rst_n) begin
      gnt    <= 1'b0;
      rvalid <= 1'b0;
      pending.delete();
    end else begin
      rvalid <= 1'b0;
      if (pending.size() != 0 && rand_bit()) begin
        rvalid <= 1'b1;
        rdata  <= mem_word(pending.pop_front());
      end
      gnt <= 1'b0;
      if (bus_req && rand_bit()) begin
        gnt <= 1'b1;
        pending.push_back(bus_addr);  // accepted at the coming edge
      end
    end
  end

  // watchdog and checker failures
  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("TEST RESULT: FAIL");
      $fatal(1, "timeout: fetch did not reach the expected pc in %0d cycles", cycles);
    end
  end

  always @(negedge clk) begin
    if (fetch_top_inst.fetch_assertions_inst.err_count != 0) begin
      $display("TEST RESULT: FAIL");
      $fatal(1, "checker reported an error");
    end
  end

  task automatic set_pc(fetch_pkg::pc_mux_e sel);
    @(negedge clk);
    pc_set = 1'b1;
    pc_mux = sel;
    @(negedge clk);
    pc_set = 1'b0;
  endtask

  task automatic wait_for_pc(fetch_pkg::addr_t a);
    do @(negedge clk); while (!(valid_id && pc_id == a));
  endtask

  initial begin
    fetch_pkg::addr_t refetch;
    clk       = 1'b0;
    rst_n     = 1'b1;
    req       = 1'b0;
    pc_set    = 1'b0;
    halt      = 1'b0;
    id_ready  = 1'b1;
    clr_valid = 1'b0;
    gnt       = 1'b0;
    rvalid    = 1'b0;
    rdata     = '0;
    pc_mux    = fetch_pkg::PC_BOOT;
    exc_mux   = fetch_pkg::EXC_PC_EXCEPTION;
    trap_base = 24'h000020;
    cause     = 5'd5;
    boot_addr = 32'h0000_0082;
    jump_id   = 32'h0000_0400;
    jump_ex   = 32'h0000_1000;
    mepc      = 32'h0000_3000;
    #1 rst_n = 1'b0;
    repeat (5) @(negedge clk);
    rst_n = 1'b1;

    // boot
    @(negedge clk);
    req = 1'b1;
    pc_set = 1'b1;
    @(negedge clk);
    pc_set = 1'b0;
    wait_for_pc(32'h80);
    wait_for_pc(32'h90);

    // random back-pressure, ID also flushes its valid bit now and then
    repeat (40) begin
      @(negedge clk);
      id_ready  = rand_bit();
      halt      = rand_bit();
      clr_valid = rand_bit();
    end
    id_ready  = 1'b1;
    halt      = 1'b0;
    clr_valid = 1'b0;

    set_pc(fetch_pkg::PC_JUMP);
    wait_for_pc(32'h41c);
    wait_for_pc(32'h424);
    set_pc(fetch_pkg::PC_BRANCH);
    wait_for_pc(32'h1008);
    set_pc(fetch_pkg::PC_EXCEPTION);
    wait_for_pc(32'h2004);
    exc_mux = fetch_pkg::EXC_PC_IRQ;
    set_pc(fetch_pkg::PC_EXCEPTION);
    wait_for_pc(32'h2018);
    set_pc(fetch_pkg::PC_MRET);
    wait_for_pc(32'h3008);
    id_ready = 1'b0;          // ID holds the fence.i
    refetch  = pc_id + 32'd4;
    set_pc(fetch_pkg::PC_FENCEI);
    id_ready = 1'b1;
    wait_for_pc(refetch);
    repeat (10) @(negedge clk);

    if (fetch_top_inst.fetch_assertions_inst.err_count != 0) begin
      $display("TEST RESULT: FAIL");
      $fatal(1, "checker reported an error");
    end else begin
      $display("TEST RESULT: PASS");
      $finish;
    end
  end

endmodule
